// File: hdl/adder_pipe.sv
// Sliced modular adder pipe computing (a + b) mod P by choosing between sum and sum minus P
`timescale 1ns/100ps
`default_nettype none
`include "modarith_macros.svh"

module adder_pipe #(
  parameter int P     = `MODARITH_P,
  parameter int BITS  = `MODARITH_BITS,
  parameter int LEVEL = `MODARITH_LEVEL
) (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_val,
  input  wire modarith_pkg::elem_t i_a,
  input  wire modarith_pkg::elem_t i_b,
  input  wire modarith_pkg::ctl_t  i_ctl,
  input  wire logic                i_sop,
  input  wire logic                i_eop,
  input  wire logic                i_rdy,
  output logic                     o_rdy,
  output logic                     o_val,
  output modarith_pkg::elem_t      o_dat,
  output modarith_pkg::ctl_t       o_ctl,
  output logic                     o_sop,
  output logic                     o_eop
);

  localparam int SW = BITS / LEVEL;
  localparam logic [BITS-1:0] PV = BITS'(P);

  modarith_pkg::elem_t a [0:LEVEL-1];   // Operands stop at the last slice
  modarith_pkg::elem_t b [0:LEVEL-1];
  modarith_pkg::elem_t sum [0:LEVEL];   // Low BITS of a + b
  modarith_pkg::elem_t dif [0:LEVEL];   // sum - P
  modarith_pkg::ctl_t  ctl [0:LEVEL];
  logic                sop [0:LEVEL];
  logic                eop [0:LEVEL];
  logic                val [0:LEVEL];
  logic                rdy [0:LEVEL];
  logic                cy [0:LEVEL];    // Sum carry chain
  logic                bw [0:LEVEL];    // Minus-P borrow chain

  assign val[0] = i_val;
  assign a[0]   = i_a;
  assign b[0]   = i_b;
  assign ctl[0] = i_ctl;
  assign sop[0] = i_sop;
  assign eop[0] = i_eop;
  assign sum[0] = '0;
  assign dif[0] = '0;
  assign cy[0]  = 1'b0;
  assign bw[0]  = 1'b0;

  assign rdy[LEVEL] = i_rdy;
  assign o_rdy      = rdy[0];

  for (genvar g = 0; g < LEVEL; g++) begin : g_stage
    logic [SW:0] s;  // Sum slice with carry out
    logic [SW:0] m;  // Sum slice minus P slice with borrow out on top

    assign rdy[g] = ~val[g+1] | rdy[g+1];

    assign s = {1'b0, a[g][g*SW +: SW]} + {1'b0, b[g][g*SW +: SW]} + {{SW{1'b0}}, cy[g]};
    assign m = {1'b0, s[SW-1:0]} - {1'b0, PV[g*SW +: SW]} - {{SW{1'b0}}, bw[g]};

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        val[g+1] <= 1'b0;
      end else if (rdy[g]) begin
        val[g+1] <= val[g];
      end
    end

    always_ff @(posedge i_clk) begin
      if (rdy[g]) begin
        ctl[g+1] <= ctl[g];
        sop[g+1] <= sop[g];
        eop[g+1] <= eop[g];
        sum[g+1]             <= sum[g];
        sum[g+1][g*SW +: SW] <= s[SW-1:0];
        dif[g+1]             <= dif[g];
        dif[g+1][g*SW +: SW] <= m[SW-1:0];
        cy[g+1] <= s[SW];
        bw[g+1] <= m[SW];
      end
    end

    // Operands only feed the next slice
    if (g < LEVEL - 1) begin : g_fwd
      always_ff @(posedge i_clk) begin
        if (rdy[g]) begin
          a[g+1] <= a[g];
          b[g+1] <= b[g];
        end
      end
    end
  end

  // Carry out or no borrow both mean sum >= P
  assign o_dat = (cy[LEVEL] | ~bw[LEVEL]) ? dif[LEVEL] : sum[LEVEL];
  assign o_val = val[LEVEL];
  assign o_ctl = ctl[LEVEL];
  assign o_sop = sop[LEVEL];
  assign o_eop = eop[LEVEL];

  // Stalled result must hold until taken
  a_hold_on_stall : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_dat)))
    else $error("adder_pipe: output changed under back-pressure");

endmodule

`default_nettype wire

// File: hdl/mod_addsub_unit.sv
// Modular add/subtract unit, dispatches beats by operation and merges pipe results in order
`timescale 1ns/100ps
`default_nettype none
`include "modarith_macros.svh"

module mod_addsub_unit (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_val,
  input  wire modarith_pkg::elem_t i_a,
  input  wire modarith_pkg::elem_t i_b,
  input  wire modarith_pkg::op_e   i_op,
  input  wire modarith_pkg::ctl_t  i_ctl,
  input  wire logic                i_sop,
  input  wire logic                i_eop,
  input  wire logic                i_rdy,
  output logic                     o_rdy,
  output logic                     o_val,
  output modarith_pkg::elem_t      o_dat,
  output modarith_pkg::ctl_t       o_ctl,
  output logic                     o_sop,
  output logic                     o_eop
);

  logic                q_full, q_empty;
  modarith_pkg::op_e   q_op;           // Owner of next result
  logic                in_sub, head_sub;
  logic                sub_i_val, sub_i_rdy, sub_o_rdy, sub_o_val, sub_o_sop, sub_o_eop;
  logic                add_i_val, add_i_rdy, add_o_rdy, add_o_val, add_o_sop, add_o_eop;
  modarith_pkg::elem_t sub_o_dat, add_o_dat;
  modarith_pkg::ctl_t  sub_o_ctl, add_o_ctl;

  assign in_sub   = (i_op == modarith_pkg::OP_SUB);
  assign head_sub = (q_op == modarith_pkg::OP_SUB);

  // Dispatch, valid only to the selected pipe and only with queue space
  assign sub_i_val = i_val & ~q_full & in_sub;
  assign add_i_val = i_val & ~q_full & ~in_sub;
  assign o_rdy     = ~q_full & (in_sub ? sub_o_rdy : add_o_rdy);

  // Merge, only the head owner sees downstream ready
  assign sub_i_rdy = head_sub & i_rdy;
  assign add_i_rdy = ~head_sub & i_rdy;

  always_comb begin
    o_val = head_sub ? sub_o_val : add_o_val;
    o_dat = head_sub ? sub_o_dat : add_o_dat;
    o_ctl = head_sub ? sub_o_ctl : add_o_ctl;
    o_sop = head_sub ? sub_o_sop : add_o_sop;
    o_eop = head_sub ? sub_o_eop : add_o_eop;
  end

  subtractor_pipe #(
    .P(`MODARITH_P), .BITS(`MODARITH_BITS), .LEVEL(`MODARITH_LEVEL)
  ) sub_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_val(sub_i_val), .i_a(i_a), .i_b(i_b), .i_ctl(i_ctl),
    .i_sop(i_sop), .i_eop(i_eop), .i_rdy(sub_i_rdy), .o_rdy(sub_o_rdy), .o_val(sub_o_val),
    .o_dat(sub_o_dat), .o_ctl(sub_o_ctl), .o_sop(sub_o_sop), .o_eop(sub_o_eop)
  );

  adder_pipe #(
    .P(`MODARITH_P), .BITS(`MODARITH_BITS), .LEVEL(`MODARITH_LEVEL)
  ) add_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_val(add_i_val), .i_a(i_a), .i_b(i_b), .i_ctl(i_ctl),
    .i_sop(i_sop), .i_eop(i_eop), .i_rdy(add_i_rdy), .o_rdy(add_o_rdy), .o_val(add_o_val),
    .o_dat(add_o_dat), .o_ctl(add_o_ctl), .o_sop(add_o_sop), .o_eop(add_o_eop)
  );

  op_order_fifo order_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (i_val & o_rdy),   // Every accepted beat
    .i_op    (i_op),
    .i_pop   (o_val & i_rdy),   // Every output transfer
    .o_op    (q_op),
    .o_empty (q_empty),
    .o_full  (q_full)
  );

  // A pipe result always has a queue entry behind it
  a_val_needs_entry : assert property (@(posedge i_clk) disable iff (i_rst)
    q_empty |-> !o_val) else $error("mod_addsub_unit: o_val with empty order queue");

endmodule

`default_nettype wire

// File: hdl/modarith_macros.svh
// Modular add/subtract parameters: modulus, operand width, pipe depth, tag width, queue depth
`ifndef MODARITH_MACROS_SVH
`define MODARITH_MACROS_SVH

// Prime modulus, operands arrive already reduced below it
`define MODARITH_P 65521

// Field element width in bits
`define MODARITH_BITS 16

// Stages per pipe, must divide MODARITH_BITS
`define MODARITH_LEVEL 2

`define MODARITH_CTL_BITS 8 // User tag width

// Order queue depth, at least 2*LEVEL so both pipes can fill
`define MODARITH_FIFO_DEPTH 8

`endif

// File: hdl/modarith_pkg.sv
// Modular arithmetic package: element, tag and queue pointer types plus the operation code
`default_nettype none
`include "modarith_macros.svh"

package modarith_pkg;

  // Field element below P
  typedef logic [`MODARITH_BITS-1:0] elem_t;

  typedef logic [`MODARITH_CTL_BITS-1:0] ctl_t; // Opaque user tag

  // Read/write pointer into the order queue
  typedef logic [$clog2(`MODARITH_FIFO_DEPTH)-1:0] qptr_t;

  // Operation select, one bit on the wire
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } op_e;

endpackage

`default_nettype wire

// File: hdl/op_order_fifo.sv
// Order queue of operation codes, head tells the merge which pipe owns the next result
`timescale 1ns/100ps
`default_nettype none
`include "modarith_macros.svh"

module op_order_fifo (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire logic              i_push,
  input  wire modarith_pkg::op_e i_op,
  input  wire logic              i_pop,
  output modarith_pkg::op_e      o_op,
  output logic                   o_empty,
  output logic                   o_full
);

  localparam int DEPTH = `MODARITH_FIFO_DEPTH;
  localparam int CW    = $clog2(DEPTH + 1);

  modarith_pkg::op_e   mem [DEPTH];
  modarith_pkg::qptr_t wr_ptr;
  modarith_pkg::qptr_t rd_ptr;
  logic [CW-1:0]       count;   // Occupancy, 0..DEPTH

  // Storage, written only on push
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_op;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == modarith_pkg::qptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == modarith_pkg::qptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (i_pop && !i_push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign o_op    = mem[rd_ptr];  // Head, no read latency
  assign o_empty = (count == '0);
  assign o_full  = (count == CW'(DEPTH));

  a_no_overflow : assert property (@(posedge i_clk) disable iff (i_rst)
    i_push |-> !o_full) else $error("op_order_fifo: push while full");
  a_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
    i_pop |-> !o_empty) else $error("op_order_fifo: pop while empty");

endmodule

`default_nettype wire

// File: hdl/subtractor_pipe.sv
// Sliced modular subtractor pipe computing (a - b) mod P with borrow select of the P-corrected result
`timescale 1ns/100ps
`default_nettype none
`include "modarith_macros.svh"

module subtractor_pipe #(
  parameter int P     = `MODARITH_P,
  parameter int BITS  = `MODARITH_BITS,
  parameter int LEVEL = `MODARITH_LEVEL
) (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_val,
  input  wire modarith_pkg::elem_t i_a,
  input  wire modarith_pkg::elem_t i_b,
  input  wire modarith_pkg::ctl_t  i_ctl,
  input  wire logic                i_sop,
  input  wire logic                i_eop,
  input  wire logic                i_rdy,
  output logic                     o_rdy,
  output logic                     o_val,
  output modarith_pkg::elem_t      o_dat,
  output modarith_pkg::ctl_t       o_ctl,
  output logic                     o_sop,
  output logic                     o_eop
);

  localparam int SW = BITS / LEVEL;              // Slice width per stage
  localparam logic [BITS-1:0] PV = BITS'(P);

  // Index 0 is the pipe input and index LEVEL the output register
  modarith_pkg::elem_t a [0:LEVEL-1];            // Operands stop at the last slice
  modarith_pkg::elem_t b [0:LEVEL-1];
  modarith_pkg::elem_t res0 [0:LEVEL];           // Plain a - b filled slice by slice
  modarith_pkg::elem_t res1 [0:LEVEL];           // a + P - b
  modarith_pkg::ctl_t  ctl [0:LEVEL];
  logic                sop [0:LEVEL];
  logic                eop [0:LEVEL];
  logic                val [0:LEVEL];
  logic                rdy [0:LEVEL];
  logic                bw0 [0:LEVEL];            // Borrow of plain chain
  logic signed [1:0]   k1 [0:LEVEL-1];           // Signed carry of corrected chain

  assign val[0]  = i_val;
  assign a[0]    = i_a;
  assign b[0]    = i_b;
  assign ctl[0]  = i_ctl;
  assign sop[0]  = i_sop;
  assign eop[0]  = i_eop;
  assign res0[0] = '0;
  assign res1[0] = '0;
  assign bw0[0]  = 1'b0;
  assign k1[0]   = 2'sd0;

  assign rdy[LEVEL] = i_rdy;  // Downstream ready closes the chain
  assign o_rdy      = rdy[0];

  for (genvar g = 0; g < LEVEL; g++) begin : g_stage
    logic [SW:0]          d0;  // Plain slice with borrow out on top
    logic signed [SW+1:0] d1;  // Corrected slice with signed carry in top two bits

    // Advance when next stage is empty or itself advancing
    assign rdy[g] = ~val[g+1] | rdy[g+1];

    assign d0 = {1'b0, a[g][g*SW +: SW]} - {1'b0, b[g][g*SW +: SW]}
              - {{SW{1'b0}}, bw0[g]};

    // a + P - b in one pass with a signed two-bit carry
    assign d1 = $signed({2'b00, a[g][g*SW +: SW]} + {2'b00, PV[g*SW +: SW]}
              - {2'b00, b[g][g*SW +: SW]} + {{SW{k1[g][1]}}, k1[g]});

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        val[g+1] <= 1'b0;
      end else if (rdy[g]) begin
        val[g+1] <= val[g];
      end
    end

    always_ff @(posedge i_clk) begin
      if (rdy[g]) begin
        ctl[g+1] <= ctl[g];
        sop[g+1] <= sop[g];
        eop[g+1] <= eop[g];
        res0[g+1]             <= res0[g];
        res0[g+1][g*SW +: SW] <= d0[SW-1:0]; // Overwrite this stage's slice
        res1[g+1]             <= res1[g];
        res1[g+1][g*SW +: SW] <= d1[SW-1:0];
        bw0[g+1] <= d0[SW];
      end
    end

    // Operands and corrected carry only feed the next slice
    if (g < LEVEL - 1) begin : g_fwd
      always_ff @(posedge i_clk) begin
        if (rdy[g]) begin
          a[g+1]  <= a[g];
          b[g+1]  <= b[g];
          k1[g+1] <= d1[SW+1:SW];
        end
      end
    end
  end

  // Final borrow means a < b so the P-corrected result is taken
  assign o_dat = bw0[LEVEL] ? res1[LEVEL] : res0[LEVEL];
  assign o_val = val[LEVEL];
  assign o_ctl = ctl[LEVEL];
  assign o_sop = sop[LEVEL];
  assign o_eop = eop[LEVEL];

  // Result fully reduced after all slices
  a_dat_reduced : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_dat < P))
    else $error("subtractor_pipe: o_dat 0x%0h not below P", o_dat);

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
// Testbench clock and reset source, 40 ns clock with reset held for 8 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;  // 40 ns period
  end

  initial begin
    o_rst = 1'b1;
    repeat (8) @(posedge o_clk);
    o_rst <= 1'b0;               // Released on an edge like the DUT expects
  end

endmodule

`default_nettype wire

// File: sim/tb_mod_addsub_unit.sv
// Testbench for the modular add/subtract unit with a scoreboard checked by concurrent assertions
`timescale 1ns/100ps
`default_nettype none
`include "modarith_macros.svh"

module tb_mod_addsub_unit;

  localparam int P           = `MODARITH_P;
  localparam int LEVEL       = `MODARITH_LEVEL;
  localparam int TOTAL_BEATS = 24 + 24 + 40 + 40 + 30;
  localparam longint WDOG_NS = longint'(TOTAL_BEATS) * (LEVEL + 4) * 40 * 4;

  typedef struct packed {
    logic                timed;  // Latency checked for this beat
    int unsigned         cyc;    // Cycle of input transfer
    logic                eop;
    logic                sop;
    modarith_pkg::ctl_t  ctl;
    modarith_pkg::elem_t dat;
  } exp_t;

  logic clk, rst;
  logic i_val, i_sop, i_eop, i_rdy, o_rdy, o_val, o_sop, o_eop;
  modarith_pkg::elem_t i_a, i_b, o_dat;
  modarith_pkg::op_e   i_op;
  modarith_pkg::ctl_t  i_ctl, o_ctl;

  integer      seed;
  int          err_cnt = 0, err_mark = 0, pass_cnt = 0, fail_cnt = 0, beat_cnt = 0;
  int unsigned cyc = 0;
  logic        bp_on, thru_on, have_exp = 1'b0;
  logic        stall_draw = 1'b1;  // Next random i_rdy value
  exp_t        exp_q[$];
  exp_t        head = '0;  // Oldest pending result, registered

  tb_clkgen clkgen_i (.o_clk(clk), .o_rst(rst));

  mod_addsub_unit dut_i (
    .i_clk(clk), .i_rst(rst), .i_val(i_val), .i_a(i_a), .i_b(i_b), .i_op(i_op),
    .i_ctl(i_ctl), .i_sop(i_sop), .i_eop(i_eop), .i_rdy(i_rdy), .o_rdy(o_rdy),
    .o_val(o_val), .o_dat(o_dat), .o_ctl(o_ctl), .o_sop(o_sop), .o_eop(o_eop)
  );

  // Reference model straight from the field rules
  function automatic modarith_pkg::elem_t model(modarith_pkg::op_e op, int a, int b);
    int r;
    r = (op == modarith_pkg::OP_SUB) ? a - b : a + b;
    if (r < 0) r += P;         // Borrow wraps into the field
    else if (r >= P) r -= P;
    return modarith_pkg::elem_t'(r);
  endfunction

  function automatic modarith_pkg::elem_t rand_elem();
    int unsigned r;
    r = $random(seed);
    return modarith_pkg::elem_t'(r % P);
  endfunction

  // Scoreboard push on input transfer and pop on output transfer
  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
    end else begin
      if (i_val && o_rdy) begin
        exp_q.push_back({thru_on, cyc, i_eop, i_sop, i_ctl, model(i_op, i_a, i_b)});
      end
      if (o_val && i_rdy && exp_q.size() != 0) void'(exp_q.pop_front());
    end
    head     <= (exp_q.size() != 0) ? exp_q[0] : '0;
    have_exp <= (exp_q.size() != 0);
    cyc      <= cyc + 1;
  end

  // Stall bit drawn between rising edges
  always @(negedge clk) stall_draw = 1'($random(seed));
  always @(posedge clk) i_rdy <= bp_on ? stall_draw : 1'b1;  // Random stalls in test 5

  a_reset_quiet : assert property (@(posedge clk) rst |=> !o_val)
    else begin
      err_cnt++;
      $display("o_val went high during or right after reset");
    end
  a_no_extra : assert property (@(posedge clk) disable iff (rst) (o_val && i_rdy) |-> have_exp)
    else begin
      err_cnt++;
      $display("Output transfer with no result pending");
    end
  a_dat : assert property (@(posedge clk) disable iff (rst)
    (o_val && i_rdy && have_exp) |-> (o_dat == head.dat)) else begin
    err_cnt++;
    $display("Mismatch o_dat: expected 0x%0h, actual 0x%0h",
             $sampled(head.dat), $sampled(o_dat));
  end
  a_ctl : assert property (@(posedge clk) disable iff (rst)
    (o_val && i_rdy && have_exp) |-> (o_ctl == head.ctl)) else begin
    err_cnt++;
    $display("Mismatch o_ctl: expected 0x%0h, actual 0x%0h",
             $sampled(head.ctl), $sampled(o_ctl));
  end
  a_frame : assert property (@(posedge clk) disable iff (rst)
    (o_val && i_rdy && have_exp) |-> ({o_sop, o_eop} == {head.sop, head.eop})) else begin
    err_cnt++;
    $display("Mismatch o_sop/o_eop: expected 0x%0h, actual 0x%0h",
             $sampled({head.sop, head.eop}), $sampled({o_sop, o_eop}));
  end
  a_hold : assert property (@(posedge clk) disable iff (rst) (o_val && !i_rdy) |=>
    (o_val && $stable(o_dat) && $stable(o_ctl) && $stable(o_sop) && $stable(o_eop)))
    else begin
      err_cnt++;
      $display("Output changed while stalled by i_rdy");
    end
  a_full_rate : assert property (@(posedge clk) disable iff (rst) (thru_on && i_val) |-> o_rdy)
    else begin
      err_cnt++;
      $display("o_rdy dropped at full rate with no back-pressure");
    end
  a_latency : assert property (@(posedge clk) disable iff (rst)
    (o_val && i_rdy && have_exp && head.timed) |-> (cyc - head.cyc == LEVEL)) else begin
    err_cnt++;
    $display("Mismatch latency: expected 0x%0h, actual 0x%0h",
             LEVEL, $sampled(cyc - head.cyc));
  end

  // One beat held until accepted, tag counts accepted beats in frames of four
  task automatic send_beat(modarith_pkg::op_e op, modarith_pkg::elem_t a, modarith_pkg::elem_t b);
    i_val <= 1'b1;
    i_op  <= op;
    i_a   <= a;
    i_b   <= b;
    i_ctl <= modarith_pkg::ctl_t'(beat_cnt);
    i_sop <= (beat_cnt % 4 == 0);
    i_eop <= (beat_cnt % 4 == 3);
    @(posedge clk);
    while (!o_rdy) @(posedge clk);
    beat_cnt++;
  endtask

  // Mode 0 is sub, 1 add and 2 a random mix
  task automatic send_random(int n, int mode);
    modarith_pkg::op_e op;
    for (int k = 0; k < n; k++) begin
      if (mode == 2) op = ($random(seed) & 1) ? modarith_pkg::OP_SUB : modarith_pkg::OP_ADD;
      else op = (mode == 0) ? modarith_pkg::OP_SUB : modarith_pkg::OP_ADD;
      send_beat(op, rand_elem(), rand_elem());
    end
  endtask

  task automatic drain();
    i_val <= 1'b0;
    @(posedge clk);
    while (exp_q.size() != 0 || o_val) @(posedge clk);
  endtask

  task automatic report_test(int num, string name);
    int errs;
    errs = err_cnt - err_mark;
    if (errs == 0) pass_cnt++;
    else fail_cnt++;
    $display("Test %0d %s: %0d errors, %0d beats so far", num, name, errs, beat_cnt);
    err_mark = err_cnt;
  endtask

  initial begin
    #(WDOG_NS);
    $display("Watchdog expired: the run hung with %0d results still pending", exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    seed = 42210;
    {i_val, i_sop, i_eop, bp_on, thru_on} = '0;
    i_rdy = 1'b1;
    i_a   = '0;
    i_b   = '0;
    i_ctl = '0;
    i_op  = modarith_pkg::OP_ADD;
    while (rst !== 1'b0) @(posedge clk);
    repeat (2) @(posedge clk);
    report_test(1, "reset");
    send_beat(modarith_pkg::OP_SUB, 5, 9);         // b > a
    send_beat(modarith_pkg::OP_SUB, 1234, 1234);   // a = b
    send_beat(modarith_pkg::OP_SUB, 77, P - 1);
    send_beat(modarith_pkg::OP_SUB, 0, P - 1);
    send_random(20, 0);
    drain();
    report_test(2, "subtract");
    send_beat(modarith_pkg::OP_ADD, P - 1, 1);     // Sum exactly P
    send_beat(modarith_pkg::OP_ADD, P - 1, P - 1); // Carry out of the width
    send_beat(modarith_pkg::OP_ADD, 0, 0);
    send_beat(modarith_pkg::OP_ADD, 40000, 30000);
    send_random(20, 1);
    drain();
    report_test(3, "add");
    send_random(40, 2);
    drain();
    report_test(4, "ordering and tags");
    bp_on <= 1'b1;
    send_random(40, 2);
    drain();
    bp_on <= 1'b0;
    repeat (2) @(posedge clk);
    report_test(5, "back-pressure");
    thru_on <= 1'b1;
    send_random(30, 2);
    thru_on <= 1'b0;
    drain();
    report_test(6, "throughput");
    $display("Tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/modarith_pkg.sv
hdl/subtractor_pipe.sv
hdl/adder_pipe.sv
hdl/op_order_fifo.sv
hdl/mod_addsub_unit.sv
sim/tb_clkgen.sv
sim/tb_mod_addsub_unit.sv
